// File: flist.f
+incdir+verilog
verilog/spi_ctl_pkg.sv
verilog/spi_word_slave.sv
verilog/cmd_decoder.sv
verilog/word_ram.sv
verilog/seg_display.sv
verilog/spi_ctl_top.sv
dv/tb_spi_ctl_top.sv

// File: Makefile
# Verilator simulation of the SPI control path.
TOP = tb_spi_ctl_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// File: dv/tb_spi_ctl_top.sv
`timescale 1ns/1ps
`include "spi_ctl_consts.svh"

module tb_spi_ctl_top;

    logic clk_50MHz;
    logic reset;
    logic spi_sck;
    logic spi_cs;
    logic spi_mosi;
    logic spi_miso;
    logic [7:0] seg;
    logic [3:0] dig;

    integer seed;
    int checks;
    int errors;
    int tests;
    int test_err_start;

    // reference model of the RAM, the result register and the display register.
    logic [`WORD_W-1:0] model_mem [0:(1 << `RAM_ADDR_W)-1];
    logic [`WORD_W-1:0] model_result;
    logic [`WORD_W-1:0] model_disp;
    logic [`RAM_ADDR_W-1:0] written_q [$];  // addresses that hold known data.

    spi_ctl_top #(
        .scan_div_p (4)
    ) spi_ctl_top_inst (
        .clk_50MHz  (clk_50MHz),
        .reset      (reset),
        .spi_sck_i  (spi_sck),
        .spi_cs_i   (spi_cs),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .seg_o      (seg),
        .dig_o      (dig)
    );

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk_50MHz);
    endtask

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [15:0] rand_word();
        return 16'($random(seed));
    endfunction

    function automatic logic [15:0] cmd_word(input logic [7:0] op);
        logic [15:0] w;
        w = rand_word();
        return {op, w[7:0]};
    endfunction

    // a known address with random bits above the RAM address range.
    function automatic logic [31:0] pick_written_addr();
        int idx;
        logic [31:0] upper;
        idx = int'($unsigned($random(seed)) % written_q.size());
        upper = $random(seed);
        return {upper[31:`RAM_ADDR_W], written_q[idx]};
    endfunction

    // active-low segments from the lit letters of the usual hex font.
    function automatic logic [7:0] seg_pattern(input logic [3:0] nib);
        string lit;
        logic [6:0] lit_mask;
        int seg_bit;
        case (nib)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcdfg";
            4'hA: lit = "abcefg";
            4'hB: lit = "cdefg";
            4'hC: lit = "adef";
            4'hD: lit = "bcdeg";
            4'hE: lit = "adefg";
            default: lit = "aefg";
        endcase
        lit_mask = '0;
        for (int i = 0; i < lit.len(); i++) begin
            seg_bit = int'(lit[i]) - int'("a");
            lit_mask = lit_mask | (7'(1) << seg_bit);
        end
        return {1'b1, ~lit_mask};
    endfunction

    // sends one mode-0 frame with five-cycle sck half-periods. miso is read before each rise.
    task automatic send_frame(input logic [15:0] tx);
        logic [15:0] rx;
        @(posedge clk_50MHz);
        spi_cs <= 1'b0;
        spi_mosi <= tx[15];
        for (int i = 15; i >= 0; i--) begin
            tick(4);
            @(negedge clk_50MHz);
            rx[i] = spi_miso;
            @(posedge clk_50MHz);
            spi_sck <= 1'b1;
            tick(5);
            spi_sck <= 1'b0;
            if (i > 0) begin
                spi_mosi <= tx[i-1];
            end
        end
        tick(5);
        spi_cs <= 1'b1;
        spi_mosi <= 1'b0;
        tick(8);  // the command finishes well inside this gap.
        check_value(rx, model_result, "frame response");
    endtask

    task automatic mem_write(input logic [31:0] addr, input logic [15:0] data);
        send_frame(cmd_word(`CMD_MEM_WRITE));
        send_frame(addr[15:0]);
        send_frame(addr[31:16]);
        send_frame(data);
        model_mem[addr[`RAM_ADDR_W-1:0]] = data;
        model_result = data;
        written_q.push_back(addr[`RAM_ADDR_W-1:0]);
    endtask

    task automatic mem_read(input logic [31:0] addr);
        send_frame(cmd_word(`CMD_MEM_READ));
        send_frame(addr[15:0]);
        send_frame(addr[31:16]);
        model_result = model_mem[addr[`RAM_ADDR_W-1:0]];
    endtask

    task automatic wait_digit(input int k);
        int cnt;
        logic [3:0] want;
        want = ~(4'b0001 << k);
        cnt = 0;
        @(negedge clk_50MHz);
        while (dig !== want && cnt < 50) begin
            @(negedge clk_50MHz);
            cnt++;
        end
        if (dig !== want) begin
            $display("timeout: digit %0d was never enabled", k);
            $display("Result: FAILED");
            $finish;
        end
    endtask

    // checks one full scan by sampling each digit while it is enabled.
    task automatic check_display();
        for (int k = 0; k < 4; k++) begin
            wait_digit(k);
            check_value({8'h00, seg}, {8'h00, seg_pattern(model_disp[4*k +: 4])},
                        $sformatf("segments of digit %0d", k));
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - test_err_start);
        test_err_start = errors;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] alias_addr;
        logic [31:0] r;
        logic [15:0] data;
        logic [15:0] word;
        seed = 41;
        checks = 0;
        errors = 0;
        tests = 0;
        test_err_start = 0;
        model_result = '0;
        model_disp = '0;
        reset <= 1'b1;
        spi_sck <= 1'b0;
        spi_cs <= 1'b1;
        spi_mosi <= 1'b0;
        tick(10);
        reset <= 1'b0;
        tick(2);

        send_frame(16'h0000);  // high byte 00 is not a command.
        check_display();
        end_test("after_reset");

        addr = $random(seed);
        data = rand_word();
        mem_write(addr, data);
        mem_write(addr ^ 32'h1, ~data);  // the result now differs from the word read back.
        mem_read(addr);
        send_frame(16'h0000);
        end_test("write_then_read");

        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            addr = $random(seed);
            if (written_q.size() == 0 || r[0]) begin
                mem_write(addr, rand_word());
            end else begin
                mem_read(pick_written_addr());
            end
        end
        send_frame(16'h0000);
        end_test("random_access");

        for (int n = 0; n < 10; n++) begin
            word = cmd_word(`CMD_DISPLAY);
            send_frame(word);
            model_disp = word;
            check_display();
        end
        end_test("display");

        for (int n = 0; n < 50; n++) begin
            word = rand_word();
            while (word[15:8] == `CMD_MEM_READ || word[15:8] == `CMD_MEM_WRITE
                   || word[15:8] == `CMD_DISPLAY) begin
                word = rand_word();
            end
            send_frame(word);
        end
        check_display();
        for (int n = 0; n < 20; n++) begin
            mem_read(pick_written_addr());
        end
        send_frame(16'h0000);
        end_test("unknown_commands");

        for (int n = 0; n < 10; n++) begin
            addr = $random(seed);
            r = $random(seed);
            alias_addr = addr ^ {r[31:`RAM_ADDR_W] | 24'h1, 8'h00};
            mem_write(addr, rand_word());
            mem_read(alias_addr);
            mem_write(alias_addr, rand_word());
            mem_read(addr);
        end
        send_frame(16'h0000);
        end_test("address_aliasing");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/spi_ctl_top.sv
`timescale 1ns/1ps
`include "spi_ctl_consts.svh"

module spi_ctl_top #(
    parameter int scan_div_p = `SCAN_DIV_DEFAULT
) (
    input  logic       clk_50MHz,
    input  logic       reset,
    input  logic       spi_sck_i,
    input  logic       spi_cs_i,
    input  logic       spi_mosi_i,
    output logic       spi_miso_o,
    output logic [7:0] seg_o,
    output logic [3:0] dig_o
);
    import spi_ctl_pkg::*;

    word_t rx_word;
    logic rx_valid;
    word_t result;
    word_t disp_word;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    spi_word_slave spi_word_slave_inst (
        .clk_50MHz  (clk_50MHz),
        .reset      (reset),
        .sck_i      (spi_sck_i),
        .cs_i       (spi_cs_i),
        .mosi_i     (spi_mosi_i),
        .miso_o     (spi_miso_o),
        .tx_word_i  (result),  // every frame returns the last result.
        .rx_word_o  (rx_word),
        .rx_valid_o (rx_valid)
    );

    cmd_decoder cmd_decoder_inst (
        .clk_50MHz   (clk_50MHz),
        .reset       (reset),
        .rx_word_i   (rx_word),
        .rx_valid_i  (rx_valid),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp),
        .result_o    (result),
        .disp_word_o (disp_word)
    );

    word_ram word_ram_inst (
        .clk_50MHz (clk_50MHz),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp)
    );

    seg_display #(
        .scan_div_p (scan_div_p)
    ) seg_display_inst (
        .clk_50MHz   (clk_50MHz),
        .reset       (reset),
        .disp_word_i (disp_word),
        .seg_o       (seg_o),
        .dig_o       (dig_o)
    );

endmodule

// File: verilog/seg_display.sv
`timescale 1ns/1ps
`include "spi_ctl_consts.svh"

module seg_display #(
    parameter int scan_div_p = `SCAN_DIV_DEFAULT
) (
    input  logic               clk_50MHz,
    input  logic               reset,
    input  spi_ctl_pkg::word_t disp_word_i,
    output logic [7:0]         seg_o,
    output logic [3:0]         dig_o
);

    localparam int cnt_w = $clog2(scan_div_p + 1);

    logic [cnt_w-1:0] scan_cnt;
    logic scan_tick;
    logic [1:0] digit_idx;
    logic [3:0] nibble;
    logic [6:0] seg_on;  // gfedcba, high means lit.

    assign scan_tick = (scan_cnt == cnt_w'(scan_div_p - 1));

    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            scan_cnt <= '0;
            digit_idx <= '0;
        end else begin
            if (scan_tick) begin
                scan_cnt <= '0;
                digit_idx <= digit_idx + 1'b1;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    assign nibble = disp_word_i[digit_idx * 4 +: 4];

    always_comb begin
        case (nibble)
            4'h0: seg_on = 7'h3F;
            4'h1: seg_on = 7'h06;
            4'h2: seg_on = 7'h5B;
            4'h3: seg_on = 7'h4F;
            4'h4: seg_on = 7'h66;
            4'h5: seg_on = 7'h6D;
            4'h6: seg_on = 7'h7D;
            4'h7: seg_on = 7'h07;
            4'h8: seg_on = 7'h7F;
            4'h9: seg_on = 7'h6F;
            4'hA: seg_on = 7'h77;
            4'hB: seg_on = 7'h7C;  // lowercase b.
            4'hC: seg_on = 7'h39;
            4'hD: seg_on = 7'h5E;  // lowercase d.
            4'hE: seg_on = 7'h79;
            default: seg_on = 7'h71;
        endcase
    end

    // segments and digit enables are active low. The decimal point stays off.
    assign seg_o = {1'b1, ~seg_on};
    assign dig_o = ~(4'b0001 << digit_idx);

endmodule

// File: verilog/word_ram.sv
`timescale 1ns/1ps
`include "spi_ctl_consts.svh"

module word_ram (
    input  logic                  clk_50MHz,
    input  spi_ctl_pkg::mem_req_t mem_req_i,
    output spi_ctl_pkg::mem_rsp_t mem_rsp_o
);
    import spi_ctl_pkg::*;

    localparam int depth = 1 << `RAM_ADDR_W;

    word_t mem_array [depth];

    // the acknowledge trails the strobe by one cycle.
    always_ff @(posedge clk_50MHz) begin
        mem_rsp_o.ack <= mem_req_i.stb;
    end

    always_ff @(posedge clk_50MHz) begin
        if (mem_req_i.stb) begin
            if (mem_req_i.we) begin
                mem_array[mem_req_i.addr] <= mem_req_i.wdata;
            end else begin
                mem_rsp_o.rdata <= mem_array[mem_req_i.addr];
            end
        end
    end

endmodule

// File: verilog/cmd_decoder.sv
`timescale 1ns/1ps
`include "spi_ctl_consts.svh"

module cmd_decoder (
    input  logic                  clk_50MHz,
    input  logic                  reset,
    input  spi_ctl_pkg::word_t    rx_word_i,
    input  logic                  rx_valid_i,
    output spi_ctl_pkg::mem_req_t mem_req_o,
    input  spi_ctl_pkg::mem_rsp_t mem_rsp_i,
    output spi_ctl_pkg::word_t    result_o,
    output spi_ctl_pkg::word_t    disp_word_o
);
    import spi_ctl_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_addr_lo,
        st_addr_hi,
        st_data,
        st_wait_ack
    } state_t;

    state_t state;
    logic op_write;  // the command in progress is a write.
    logic [7:0] cmd_byte;

    logic req_stb;
    logic req_we;
    ram_addr_t req_addr;
    word_t req_wdata;

    assign cmd_byte = rx_word_i[`WORD_W-1 -: 8];

    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            state <= st_idle;
            op_write <= 1'b0;
            req_stb <= 1'b0;
            result_o <= '0;
            disp_word_o <= '0;
        end else begin
            req_stb <= 1'b0;  // strobe lasts one cycle.
            case (state)
                st_idle: begin
                    if (rx_valid_i) begin
                        case (cmd_byte)
                            `CMD_MEM_READ: begin
                                op_write <= 1'b0;
                                state <= st_addr_lo;
                            end
                            `CMD_MEM_WRITE: begin
                                op_write <= 1'b1;
                                state <= st_addr_lo;
                            end
                            `CMD_DISPLAY: begin
                                disp_word_o <= rx_word_i;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
                st_addr_lo: begin
                    if (rx_valid_i) begin
                        state <= st_addr_hi;
                    end
                end
                st_addr_hi: begin
                    if (rx_valid_i) begin
                        if (op_write) begin
                            state <= st_data;
                        end else begin
                            req_stb <= 1'b1;
                            state <= st_wait_ack;
                        end
                    end
                end
                st_data: begin
                    if (rx_valid_i) begin
                        req_stb <= 1'b1;
                        state <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    // a write reports the data it stored.
                    if (mem_rsp_i.ack) begin
                        result_o <= req_we ? req_wdata : mem_rsp_i.rdata;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // the high address word carries no RAM address bits and is dropped.
    always_ff @(posedge clk_50MHz) begin
        if (rx_valid_i) begin
            case (state)
                st_addr_lo: req_addr <= rx_word_i[`RAM_ADDR_W-1:0];
                st_addr_hi: req_we <= op_write;
                st_data: req_wdata <= rx_word_i;
                default: begin
                end
            endcase
        end
    end

    assign mem_req_o = '{stb: req_stb, we: req_we, addr: req_addr, wdata: req_wdata};

endmodule

// File: verilog/spi_word_slave.sv
`timescale 1ns/1ps
`include "spi_ctl_consts.svh"

module spi_word_slave (
    input  logic               clk_50MHz,
    input  logic               reset,
    input  logic               sck_i,
    input  logic               cs_i,
    input  logic               mosi_i,
    output logic               miso_o,
    input  spi_ctl_pkg::word_t tx_word_i,
    output spi_ctl_pkg::word_t rx_word_o,
    output logic               rx_valid_o
);
    import spi_ctl_pkg::*;

    localparam int cnt_w = $clog2(`WORD_W);

    logic sck_meta;
    logic sck_sync;
    logic sck_prev;
    logic cs_meta;
    logic cs_sync;
    logic cs_prev;
    logic mosi_meta;
    logic mosi_sync;

    logic sck_rise;
    logic sck_fall;
    logic cs_fall;

    logic [cnt_w-1:0] bit_cnt;
    word_t rx_shift;
    word_t tx_shift;

    // two flops per pin, plus one more on sck and cs for edge detection.
    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            sck_meta <= 1'b0;
            sck_sync <= 1'b0;
            sck_prev <= 1'b0;
            cs_meta <= 1'b1;  // idle high so reset does not look like a cs edge.
            cs_sync <= 1'b1;
            cs_prev <= 1'b1;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
        end else begin
            sck_meta <= sck_i;
            sck_sync <= sck_meta;
            sck_prev <= sck_sync;
            cs_meta <= cs_i;
            cs_sync <= cs_meta;
            cs_prev <= cs_sync;
            mosi_meta <= mosi_i;
            mosi_sync <= mosi_meta;
        end
    end

    assign sck_rise = sck_sync & ~sck_prev;
    assign sck_fall = ~sck_sync & sck_prev;
    assign cs_fall = ~cs_sync & cs_prev;

    always_ff @(posedge clk_50MHz) begin
        if (reset) begin
            bit_cnt <= '0;
            rx_valid_o <= 1'b0;
            tx_shift <= '0;
        end else begin
            rx_valid_o <= 1'b0;
            if (cs_fall) begin
                tx_shift <= tx_word_i;  // the first bit is on miso before the first sck edge.
                bit_cnt <= '0;
            end else if (!cs_sync) begin
                if (sck_rise) begin
                    if (bit_cnt == cnt_w'(`WORD_W - 1)) begin
                        bit_cnt <= '0;
                        rx_valid_o <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                if (sck_fall) begin
                    tx_shift <= {tx_shift[`WORD_W-2:0], 1'b0};
                end
            end else begin
                bit_cnt <= '0;  // cs went high mid-word.
            end
        end
    end

    // received bits, MSB first.
    always_ff @(posedge clk_50MHz) begin
        if (!cs_sync && sck_rise) begin
            rx_shift <= {rx_shift[`WORD_W-2:0], mosi_sync};
            if (bit_cnt == cnt_w'(`WORD_W - 1)) begin
                rx_word_o <= {rx_shift[`WORD_W-2:0], mosi_sync};
            end
        end
    end

    assign miso_o = tx_shift[`WORD_W-1];

endmodule

// File: verilog/spi_ctl_pkg.sv
`include "spi_ctl_consts.svh"

package spi_ctl_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;

    // request from the command decoder to the word RAM.
    typedef struct packed {
        logic      stb;    // one-cycle access strobe.
        logic      we;     // high for a write.
        ram_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    // response from the word RAM.
    typedef struct packed {
        logic  ack;    // one-cycle pulse, one cycle after stb.
        word_t rdata;  // valid together with ack on a read.
    } mem_rsp_t;

endpackage

// File: verilog/spi_ctl_consts.svh
`ifndef SPI_CTL_CONSTS_SVH
`define SPI_CTL_CONSTS_SVH

// width of one SPI frame and of one RAM word.
`define WORD_W 16

// 256 words of RAM. The host still sends a 32-bit address.
`define RAM_ADDR_W 8

// command codes live in the high byte of the first word of a command.
`define CMD_MEM_READ 8'hC0
`define CMD_MEM_WRITE 8'hC1
`define CMD_DISPLAY 8'h20

// clk_50MHz cycles per digit step, which scans at 1 kHz.
`define SCAN_DIV_DEFAULT 50000

`endif
